/* hdl/exu_params.svh */
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// register address width, 32 registers
`define EXU_AW 5

// datapath width
`define EXU_DW 32

// instruction buffer entries
`define EXU_BUF_DEPTH 2

`endif

/* hdl/exu_pkg.sv */
`include "exu_params.svh"

package exu_pkg;

   // alu operation codes
   // rsub is second operand minus first
   // srl shifts first operand by low bits of second
   typedef enum logic [2:0] {
      ADD  = 3'd0,
      RSUB = 3'd1,
      AND  = 3'd2,
      OR   = 3'd3,
      XOR  = 3'd4,
      SRL  = 3'd5
   } alu_op_e;

   // register form, operands from ra and rb
   typedef struct packed {
      logic [1:0]         spare;
      logic               is_imm;
      alu_op_e            op;
      logic [`EXU_AW-1:0] rd;
      logic [`EXU_AW-1:0] ra;
      logic [`EXU_AW-1:0] rb;
      logic [10:0]        unused;
   } inst_rform_t;

   // immediate form, second operand is imm16 sign extended
   typedef struct packed {
      logic [1:0]         spare;
      logic               is_imm;
      alu_op_e            op;
      logic [`EXU_AW-1:0] rd;
      logic [`EXU_AW-1:0] ra;
      logic signed [15:0] imm16;
   } inst_iform_t;

   // one instruction word, two views
   // is_imm sits at the same bit in both, so either view can pick the format
   typedef union packed {
      inst_rform_t r;
      inst_iform_t i;
   } inst_u;

endpackage

/* hdl/exu_stage_if.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

interface exu_stage_if import exu_pkg::*; ();

   // decode register contents
   logic               d_valid;
   alu_op_e            d_op;
   logic [`EXU_AW-1:0] d_rd;
   logic [`EXU_DW-1:0] d_opa;
   logic [`EXU_DW-1:0] d_opb;

   // execute side, take strobe and forwarding path back to decode
   logic               e_take;
   logic [`EXU_DW-1:0] f_value;
   logic [`EXU_AW-1:0] f_rd;

   modport dec (
      output d_valid, d_op, d_rd, d_opa, d_opb,
      input  e_take, f_value, f_rd
   );

   modport exe (
      input  d_valid, d_op, d_rd, d_opa, d_opb,
      output e_take, f_value, f_rd
   );

endinterface

/* hdl/dparam_ram.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module dparam_ram #(
   parameter int AW = `EXU_AW,
   parameter int DW = `EXU_DW
) (
   input  logic          clk_i,
   // port a, read and write
   input  logic [AW-1:0] adr_i,
   input  logic [DW-1:0] dat_i,
   input  logic          wre_i,
   output logic [DW-1:0] dat_o,
   // port x, read only
   input  logic [AW-1:0] xadr_i,
   output logic [DW-1:0] xdat_o
);

   // distributed ram array, no reset
   logic [DW-1:0] mem [1<<AW];

   // zero contents at start of simulation
   initial begin
      for (int i = 0; i < (1 << AW); i++) begin
         mem[i] = '0;
      end
   end

   // write on port a only
   always_ff @(posedge clk_i) begin
      if (wre_i) begin
         mem[adr_i] <= dat_i;
      end
   end

   // both reads asynchronous
   assign dat_o  = mem[adr_i];
   assign xdat_o = mem[xadr_i];

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module reg_file (
   input  logic               clk_i,
   // write port from execute
   input  logic               wr_en_i,
   input  logic [`EXU_AW-1:0] wr_adr_i,
   input  logic [`EXU_DW-1:0] wr_dat_i,
   // two read ports for decode
   input  logic [`EXU_AW-1:0] ra_adr_i,
   input  logic [`EXU_AW-1:0] rb_adr_i,
   output logic [`EXU_DW-1:0] ra_dat_o,
   output logic [`EXU_DW-1:0] rb_dat_o
);

   localparam int NRD = 2;

   logic               ram_we;
   logic [`EXU_AW-1:0] rd_adr [NRD];
   logic [`EXU_DW-1:0] rd_raw [NRD];
   logic [`EXU_DW-1:0] rd_dat [NRD];

   // r0 is hardwired and never written
   assign ram_we = wr_en_i && (wr_adr_i != '0);

   assign rd_adr[0] = ra_adr_i;
   assign rd_adr[1] = rb_adr_i;

   // one ram copy per read operand
   // both copies written the same
   // port a of each copy only serves the write
   for (genvar g = 0; g < NRD; g++) begin : g_copy
      dparam_ram #(
         .AW (`EXU_AW),
         .DW (`EXU_DW)
      ) u_ram (
         .clk_i  (clk_i),
         .adr_i  (wr_adr_i),
         .dat_i  (wr_dat_i),
         .wre_i  (ram_we),
         .dat_o  (),
         .xadr_i (rd_adr[g]),
         .xdat_o (rd_raw[g])
      );

      // r0 reads zero
      assign rd_dat[g] = (rd_adr[g] == '0) ? '0 : rd_raw[g];

      // a write reaches this copy's read port one cycle later
      wr_read_a: assert property (@(posedge clk_i)
         ram_we |=> ((rd_adr[g] != $past(wr_adr_i)) || (rd_raw[g] == $past(wr_dat_i))));
   end

   assign ra_dat_o = rd_dat[0];
   assign rb_dat_o = rd_dat[1];

endmodule

/* hdl/inst_buffer.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module inst_buffer import exu_pkg::*; (
   input  logic               clk_i,
   input  logic               arst_n_i,
   // instruction stream in
   input  logic               in_valid_i,
   input  logic [`EXU_DW-1:0] in_data_i,
   output logic               in_ready_o,
   // head of queue towards decode
   output logic               out_valid_o,
   output inst_u              out_data_o,
   input  logic               out_ready_i
);

   localparam int DEPTH = `EXU_BUF_DEPTH;
   localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1);

   // payload storage
   inst_u         mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          push;
   logic          pop;

   // circular pointer step
   function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
      if (p == PW'(DEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   // ready drops only with every entry taken
   assign in_ready_o  = (count != CW'(DEPTH));
   assign out_valid_o = (count != '0);
   assign out_data_o  = mem[rd_ptr];

   assign push = in_valid_i && in_ready_o;
   assign pop  = out_valid_o && out_ready_i;

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= in_data_i;
      end
   end

   // pointers and fill level
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // fill level in range, pointers meet only when empty or full
   ptr_count_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (count <= CW'(DEPTH)) &&
      ((wr_ptr == rd_ptr) == ((count == '0) || (count == CW'(DEPTH)))));

endmodule

/* hdl/decode_read.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module decode_read import exu_pkg::*; (
   input  logic               clk_i,
   input  logic               arst_n_i,
   // buffer head
   input  logic               head_valid_i,
   input  inst_u              head_data_i,
   output logic               head_ready_o,
   // register file read
   output logic [`EXU_AW-1:0] ra_adr_o,
   output logic [`EXU_AW-1:0] rb_adr_o,
   input  logic [`EXU_DW-1:0] ra_dat_i,
   input  logic [`EXU_DW-1:0] rb_dat_i,
   // to execute
   exu_stage_if.dec           stage
);

   logic               is_imm;
   logic [`EXU_DW-1:0] imm_ext;
   logic               fwd_a;
   logic               fwd_b;
   logic [`EXU_DW-1:0] opa;
   logic [`EXU_DW-1:0] opb;
   logic               load;

   // decode register
   logic               d_valid_q;
   alu_op_e            d_op_q;
   logic [`EXU_AW-1:0] d_rd_q;
   logic [`EXU_DW-1:0] d_opa_q;
   logic [`EXU_DW-1:0] d_opb_q;

   // format flag, same bit in both views
   assign is_imm = head_data_i.r.is_imm;

   // sign extend the immediate view
   assign imm_ext = {{(`EXU_DW - 16){head_data_i.i.imm16[15]}}, head_data_i.i.imm16};

   // ra and rb always read, rb ignored in immediate form
   assign ra_adr_o = head_data_i.r.ra;
   assign rb_adr_o = head_data_i.r.rb;

   // forward from the instruction ahead, f_rd is zero when nothing valid
   assign fwd_a = (head_data_i.r.ra != '0) && (head_data_i.r.ra == stage.f_rd);
   assign fwd_b = (head_data_i.r.rb != '0) && (head_data_i.r.rb == stage.f_rd);

   assign opa = fwd_a ? stage.f_value : ra_dat_i;

   always_comb begin
      if (is_imm) begin
         opb = imm_ext;
      end else if (fwd_b) begin
         opb = stage.f_value;
      end else begin
         opb = rb_dat_i;
      end
   end

   // empty or draining into execute
   assign head_ready_o = !d_valid_q || stage.e_take;
   assign load         = head_valid_i && head_ready_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         d_valid_q <= 1'b0;
      end else if (head_ready_o) begin
         d_valid_q <= head_valid_i;
      end
   end

   // payload, loaded with the head word
   always_ff @(posedge clk_i) begin
      if (load) begin
         d_op_q  <= head_data_i.r.op;
         d_rd_q  <= head_data_i.r.rd;
         d_opa_q <= opa;
         d_opb_q <= opb;
      end
   end

   assign stage.d_valid = d_valid_q;
   assign stage.d_op    = d_op_q;
   assign stage.d_rd    = d_rd_q;
   assign stage.d_opa   = d_opa_q;
   assign stage.d_opb   = d_opb_q;

   // held while execute is stalled
   dec_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (d_valid_q && !stage.e_take) |=>
         (d_valid_q && $stable({d_op_q, d_rd_q, d_opa_q, d_opb_q})));

endmodule

/* hdl/alu_exec.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module alu_exec import exu_pkg::*; (
   input  logic               clk_i,
   input  logic               arst_n_i,
   // from decode
   exu_stage_if.exe           stage,
   // write back
   output logic               wr_en_o,
   output logic [`EXU_AW-1:0] wr_adr_o,
   output logic [`EXU_DW-1:0] wr_dat_o,
   // result stream out
   output logic               res_valid_o,
   output logic [`EXU_DW-1:0] res_data_o,
   output logic [`EXU_AW-1:0] res_rd_o,
   input  logic               res_ready_i
);

   // shift amount width, 5 bits for 32
   localparam int SHW = $clog2(`EXU_DW);

   logic [`EXU_DW-1:0] alu_res;
   logic               take;
   logic               load;

   // result register
   logic               res_valid_q;
   logic [`EXU_DW-1:0] res_data_q;
   logic [`EXU_AW-1:0] res_rd_q;

   // alu on the decode register
   always_comb begin
      case (stage.d_op)
         ADD:     alu_res = stage.d_opa + stage.d_opb;
         RSUB:    alu_res = stage.d_opb - stage.d_opa;
         AND:     alu_res = stage.d_opa & stage.d_opb;
         OR:      alu_res = stage.d_opa | stage.d_opb;
         XOR:     alu_res = stage.d_opa ^ stage.d_opb;
         SRL:     alu_res = stage.d_opa >> stage.d_opb[SHW-1:0];
         default: alu_res = '0;
      endcase
   end

   // forwarding back to decode
   // rd reported as zero when decode is empty, so it never matches
   assign stage.f_value = alu_res;
   assign stage.f_rd    = stage.d_valid ? stage.d_rd : '0;

   // result register empty or leaving this edge
   assign take         = !res_valid_q || res_ready_i;
   assign stage.e_take = take;
   assign load         = stage.d_valid && take;

   // write back on the same edge as the result load
   // reg_file drops writes to r0
   assign wr_en_o  = load;
   assign wr_adr_o = stage.d_rd;
   assign wr_dat_o = alu_res;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         res_valid_q <= 1'b0;
      end else if (take) begin
         res_valid_q <= stage.d_valid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         res_data_q <= alu_res;
         res_rd_q   <= stage.d_rd;
      end
   end

   assign res_valid_o = res_valid_q;
   assign res_data_o  = res_data_q;
   assign res_rd_o    = res_rd_q;

   // output frozen under back-pressure
   res_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (res_valid_q && !res_ready_i) |=>
         (res_valid_q && $stable(res_data_q) && $stable(res_rd_q)));

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_top import exu_pkg::*; (
   input  logic               clk_i,
   input  logic               arst_n_i,
   // instruction stream
   input  logic               inst_valid_i,
   input  logic [`EXU_DW-1:0] inst_data_i,
   output logic               inst_ready_o,
   // result stream
   output logic               res_valid_o,
   output logic [`EXU_DW-1:0] res_data_o,
   output logic [`EXU_AW-1:0] res_rd_o,
   input  logic               res_ready_i
);

   // buffer head to decode
   logic               head_valid;
   inst_u              head_data;
   logic               head_ready;
   // register file reads
   logic [`EXU_AW-1:0] ra_adr;
   logic [`EXU_AW-1:0] rb_adr;
   logic [`EXU_DW-1:0] ra_dat;
   logic [`EXU_DW-1:0] rb_dat;
   // write back
   logic               wr_en;
   logic [`EXU_AW-1:0] wr_adr;
   logic [`EXU_DW-1:0] wr_dat;

   // decode to execute, forwarding back
   exu_stage_if u_stage ();

   inst_buffer u_buf (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (inst_valid_i),
      .in_data_i   (inst_data_i),
      .in_ready_o  (inst_ready_o),
      .out_valid_o (head_valid),
      .out_data_o  (head_data),
      .out_ready_i (head_ready)
   );

   decode_read u_dec (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .head_valid_i (head_valid),
      .head_data_i  (head_data),
      .head_ready_o (head_ready),
      .ra_adr_o     (ra_adr),
      .rb_adr_o     (rb_adr),
      .ra_dat_i     (ra_dat),
      .rb_dat_i     (rb_dat),
      .stage        (u_stage.dec)
   );

   reg_file u_rf (
      .clk_i    (clk_i),
      .wr_en_i  (wr_en),
      .wr_adr_i (wr_adr),
      .wr_dat_i (wr_dat),
      .ra_adr_i (ra_adr),
      .rb_adr_i (rb_adr),
      .ra_dat_o (ra_dat),
      .rb_dat_o (rb_dat)
   );

   alu_exec u_exe (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .stage       (u_stage.exe),
      .wr_en_o     (wr_en),
      .wr_adr_o    (wr_adr),
      .wr_dat_o    (wr_dat),
      .res_valid_o (res_valid_o),
      .res_data_o  (res_data_o),
      .res_rd_o    (res_rd_o),
      .res_ready_i (res_ready_i)
   );

endmodule

/* testbench/tb_exu_top.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module tb_exu_top import exu_pkg::*; ();

   // instructions per phase
   // first phase sweeps latency at full rate
   localparam int N_PH0     = 40;
   localparam int N_PH1     = 150;
   localparam int N_PH2     = 150;
   localparam int N_PH3     = 160;
   localparam int NUM_TOTAL = N_PH0 + N_PH1 + N_PH2 + N_PH3;

   logic               clk_i;
   logic               arst_n_i;
   logic               inst_valid_i;
   logic [`EXU_DW-1:0] inst_data_i;
   logic               inst_ready_o;
   logic               res_valid_o;
   logic [`EXU_DW-1:0] res_data_o;
   logic [`EXU_AW-1:0] res_rd_o;
   logic               res_ready_i;

   integer             seed;
   int                 n_made;
   int                 n_sent;
   int                 n_res;
   int                 cyc;
   int                 first_acc_cyc;
   int                 first_res_cyc;
   logic               in_fire;
   logic               out_fire;
   logic               saw_full;
   // reference register file and expected result queue
   logic [`EXU_DW-1:0] regs [1<<`EXU_AW];
   logic [`EXU_DW-1:0] exp_data [$];
   logic [`EXU_AW-1:0] exp_rd [$];

   exu_top u_dut (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .inst_valid_i (inst_valid_i),
      .inst_data_i  (inst_data_i),
      .inst_ready_o (inst_ready_o),
      .res_valid_o  (res_valid_o),
      .res_data_o   (res_data_o),
      .res_rd_o     (res_rd_o),
      .res_ready_i  (res_ready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // single compare point for every value check
   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // uniform draw in 0..n-1
   function automatic int unsigned pick(input int unsigned n);
      return {$random(seed)} % n;
   endfunction

   // random instruction word
   // field order spare imm op rd ra then rb or imm16
   // first twelve sweep every op in register then immediate form
   function automatic logic [31:0] make_inst();
      logic [31:0] w;
      logic [2:0]  op;
      logic        is_imm;
      w = $random(seed);
      if (n_made < 12) begin
         op     = 3'(n_made % 6);
         is_imm = (n_made >= 6);
      end else begin
         op     = 3'(pick(6));
         is_imm = 1'(pick(2));
      end
      n_made++;
      w[29]    = is_imm;
      w[28:26] = op;
      // only r0..r2 for dense dependencies
      w[25:21] = 5'(pick(3));
      w[20:16] = 5'(pick(3));
      if (!is_imm) begin
         w[15:11] = 5'(pick(3));
      end
      return w;
   endfunction

   // reference alu on the model registers
   function automatic logic [31:0] model_result(input logic [31:0] w);
      logic [31:0] a;
      logic [31:0] b;
      a = regs[w[20:16]];
      if (w[29]) begin
         b = {{16{w[15]}}, w[15:0]};
      end else begin
         b = regs[w[15:11]];
      end
      case (alu_op_e'(w[28:26]))
         ADD:     return a + b;
         RSUB:    return b - a;
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         SRL:     return a >> b[4:0];
         default: return '0;
      endcase
   endfunction

   // handshakes sampled on the falling edge
   always @(negedge clk_i) begin
      logic [31:0] r;
      cyc++;
      in_fire  = arst_n_i && inst_valid_i && inst_ready_o;
      out_fire = arst_n_i && res_valid_o && res_ready_i;
      if (arst_n_i && !inst_ready_o) begin
         saw_full = 1'b1;
      end
      if (in_fire) begin
         r = model_result(inst_data_i);
         // r0 result reported but never stored
         if (inst_data_i[25:21] != '0) begin
            regs[inst_data_i[25:21]] = r;
         end
         exp_data.push_back(r);
         exp_rd.push_back(inst_data_i[25:21]);
         if (n_sent == 0) begin
            first_acc_cyc = cyc;
         end
         n_sent++;
      end
      if (out_fire) begin
         if (exp_data.size() == 0) begin
            $display("a result left the DUT with no instruction outstanding at %0t ns", $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "unexpected result");
         end else begin
            check_eq(res_data_o, exp_data.pop_front(), "result data");
            check_eq(32'(res_rd_o), 32'(exp_rd.pop_front()), "result rd");
            if (n_res == 0) begin
               first_res_cyc = cyc;
            end
            n_res++;
         end
      end
   end

   // pv and pr are percentages
   // a valid word is held until taken
   task automatic run_phase(input int n, input int pv, input int pr);
      int   issued;
      logic done;
      issued = 0;
      done   = 1'b0;
      while (!done) begin
         @(posedge clk_i);
         res_ready_i <= (pick(100) < pr);
         if (!(inst_valid_i && !in_fire)) begin
            if (issued == n) begin
               inst_valid_i <= 1'b0;
               done = 1'b1;
            end else if (pick(100) < pv) begin
               inst_valid_i <= 1'b1;
               inst_data_i  <= make_inst();
               issued++;
            end else begin
               inst_valid_i <= 1'b0;
            end
         end
      end
   endtask

   // watchdog sized from the instruction count
   initial begin
      repeat (NUM_TOTAL * 20) @(posedge clk_i);
      $display("watchdog expired, results stopped arriving (%0d of %0d)", n_res, NUM_TOTAL);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
   end

   initial begin
      seed         = 17;
      n_made       = 0;
      n_sent       = 0;
      n_res        = 0;
      cyc          = 0;
      saw_full     = 1'b0;
      in_fire      = 1'b0;
      out_fire     = 1'b0;
      arst_n_i     = 1'b0;
      inst_valid_i = 1'b0;
      inst_data_i  = '0;
      res_ready_i  = 1'b0;
      for (int i = 0; i < (1 << `EXU_AW); i++) begin
         regs[i] = '0;
      end
      repeat (16) @(posedge clk_i);
      arst_n_i <= 1'b1;
      @(negedge clk_i);
      check_eq(32'(res_valid_o), 32'd1 - 32'd1, "res_valid_o after reset");
      check_eq(32'(inst_ready_o), 32'd1, "inst_ready_o after reset");
      // full rate, idle input, heavy stalls and mixed stalls
      run_phase(N_PH0, 100, 100);
      run_phase(N_PH1, 70, 100);
      run_phase(N_PH2, 100, 30);
      run_phase(N_PH3, 50, 50);
      @(posedge clk_i);
      res_ready_i <= 1'b1;
      wait (n_res == NUM_TOTAL);
      repeat (4) @(negedge clk_i);
      check_eq(32'(res_valid_o), 32'd0, "res_valid_o after drain");
      check_eq(32'(first_res_cyc - first_acc_cyc), 32'd3, "first result latency");
      check_eq(32'(saw_full), 32'd1, "inst_ready_o dropped under stall");
      if (exp_data.size() != 0) begin
         $display("%0d expected results never left the DUT", exp_data.size());
         $display("TEST RESULT: FAIL");
         $fatal(1, "results missing");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

/* project.f */
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_stage_if.sv
hdl/dparam_ram.sv
hdl/reg_file.sv
hdl/inst_buffer.sv
hdl/decode_read.sv
hdl/alu_exec.sv
hdl/exu_top.sv
testbench/tb_exu_top.sv
